// File: rtl/ahb_mem_pkg.sv
// Shared definitions for the AHB-Lite two-bank SRAM subsystem.
// Bus widths, memory map, AHB encodings and the request/response structs.
// Every RTL file refers to these by scoped name.

package ahb_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////////////////////////

  // Byte address and data widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  // Byte lanes per data word
  localparam int unsigned BE_W = DATA_W / 8;
  // Address bits that select a lane inside a word
  localparam int unsigned WORD_LSB = $clog2(BE_W);

  //////////////////////////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////////////////////////

  // 256 words per bank, 1 KiB
  localparam int unsigned BANK_ABITS = 8;
  // First address bit above the bank offset
  localparam int unsigned BANK_LSB = WORD_LSB + BANK_ABITS;
  localparam logic [ADDR_W-1:0] BANK0_BASE = 16'h0000;
  localparam logic [ADDR_W-1:0] BANK1_BASE = 16'h0400;
  // 16'h0800 and up is unmapped, served by the default slave

  //////////////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // Default slave states, two ERROR cycles after idle
  localparam logic [1:0] DS_IDLE = 2'd0;
  localparam logic [1:0] DS_ERR1 = 2'd1;
  localparam logic [1:0] DS_ERR2 = 2'd2;

  // Master to slave, address phase fields plus data-phase write data
  typedef struct packed {
    logic [ADDR_W-1:0] haddr;
    logic              hwrite;
    logic [2:0]        hsize;
    logic [1:0]        htrans;
    logic [DATA_W-1:0] hwdata;
  } ahb_req_t;

  // Slave to master
  typedef struct packed {
    logic [DATA_W-1:0] hrdata;
    logic              hreadyout;
    logic              hresp;
  } ahb_rsp_t;

endpackage

// File: rtl/ram_1r1w.sv
// Generic byte-enabled memory, one write port and one registered read port.
// Read data appears one cycle after the read address. A same-edge write
// to the word being read is forwarded into the read data lane by lane.

module ram_1r1w #(
  parameter int unsigned ABITS = ahb_mem_pkg::BANK_ABITS
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic [ABITS-1:0]                waddr,
  input  logic                            we,
  input  logic [ahb_mem_pkg::BE_W-1:0]    be,
  input  logic [ahb_mem_pkg::DATA_W-1:0]  din,
  input  logic [ABITS-1:0]                raddr,
  output logic [ahb_mem_pkg::DATA_W-1:0]  dout
);

  // Storage, no reset on the array
  logic [ahb_mem_pkg::DATA_W-1:0] mem [2**ABITS];

  // Read register holds the word as it was before the edge
  logic [ahb_mem_pkg::DATA_W-1:0] rd_q;
  // Bytes written at the read edge, and which lanes they cover
  logic [ahb_mem_pkg::DATA_W-1:0] fwd_data_q;
  logic [ahb_mem_pkg::BE_W-1:0]   fwd_be_q;

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // Only enabled lanes are updated
  always_ff @(posedge HCLK) begin
    if (we) begin
      for (int i = 0; i < ahb_mem_pkg::BE_W; i++) begin
        if (be[i]) begin
          mem[waddr][i*8 +: 8] <= din[i*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port with write forwarding
  //////////////////////////////////////////////////////////////////////

  // Array read samples old contents
  always_ff @(posedge HCLK) begin
    rd_q       <= mem[raddr];
    fwd_data_q <= din;
  end

  // Lanes to take from the write data instead of the array
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      fwd_be_q <= '0;
    end else begin
      fwd_be_q <= (we && (waddr == raddr)) ? be : '0;
    end
  end

  // Merge new lanes over stored ones
  always_comb begin
    for (int i = 0; i < ahb_mem_pkg::BE_W; i++) begin
      dout[i*8 +: 8] = fwd_be_q[i] ? fwd_data_q[i*8 +: 8] : rd_q[i*8 +: 8];
    end
  end

endmodule

// File: rtl/ahb_sram.sv
// AHB-Lite slave wrapping one SRAM bank.
// Writes land one cycle late, at the edge that ends the data phase.
// Reads start in the address phase and return with no wait state, except
// a read of a word that still has a partial write pending stalls one cycle.

module ahb_sram (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  hsel,
  input  logic                  hready,
  input  ahb_mem_pkg::ahb_req_t req,
  output ahb_mem_pkg::ahb_rsp_t rsp
);

  // Address-phase qualifiers
  logic active;
  logic accept;

  // Captured address phase, held while HREADY is low
  logic                                 we_q;
  logic [ahb_mem_pkg::BE_W-1:0]         be_q;
  logic [ahb_mem_pkg::ADDR_W-1:0]       addr_q;

  // Stall control
  logic contention;
  logic hreadyout_q;

  // Memory side
  logic [ahb_mem_pkg::BANK_ABITS-1:0]   raddr;
  logic [ahb_mem_pkg::DATA_W-1:0]       dout;

  //////////////////////////////////////////////////////////////////////
  // Byte-enable decode
  //////////////////////////////////////////////////////////////////////

  // Lane mask from transfer size and low address bits
  function automatic logic [ahb_mem_pkg::BE_W-1:0] gen_be(
    input logic [2:0]                         hsize,
    input logic [ahb_mem_pkg::WORD_LSB-1:0]   off
  );
    logic [ahb_mem_pkg::BE_W-1:0]     mask;
    logic [ahb_mem_pkg::WORD_LSB-1:0] lane;
    case (hsize)
      ahb_mem_pkg::HSIZE_BYTE: begin
        mask = ahb_mem_pkg::BE_W'(1);
        lane = off;
      end
      ahb_mem_pkg::HSIZE_HWORD: begin
        mask = ahb_mem_pkg::BE_W'(3);
        // Halfwords sit on even lanes
        lane = {off[ahb_mem_pkg::WORD_LSB-1:1], 1'b0};
      end
      default: begin
        // Word, and anything wider is treated as a word
        mask = '1;
        lane = '0;
      end
    endcase
    return mask << lane;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Address phase capture
  //////////////////////////////////////////////////////////////////////

  // Only NONSEQ and SEQ move data
  assign active = (req.htrans == ahb_mem_pkg::HTRANS_NONSEQ) ||
                  (req.htrans == ahb_mem_pkg::HTRANS_SEQ);
  assign accept = hsel & hready & active;

  // Pending write, cleared by the next accepted phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we_q <= 1'b0;
    end else if (hready) begin
      we_q <= accept & req.hwrite;
    end
  end

  // Lanes and address of the data phase
  always_ff @(posedge HCLK) begin
    if (hready) begin
      be_q   <= gen_be(req.hsize, req.haddr[ahb_mem_pkg::WORD_LSB-1:0]);
      addr_q <= req.haddr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read after partial write
  //////////////////////////////////////////////////////////////////////

  // New read meets a pending write of the same word
  assign contention = accept & ~req.hwrite & we_q & ~&be_q &
    (addr_q[ahb_mem_pkg::WORD_LSB +: ahb_mem_pkg::BANK_ABITS] ==
     req.haddr[ahb_mem_pkg::WORD_LSB +: ahb_mem_pkg::BANK_ABITS]);

  // One wait state in the read's data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hreadyout_q <= 1'b1;
    end else begin
      hreadyout_q <= ~contention;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory
  //////////////////////////////////////////////////////////////////////

  // While stalled, keep re-reading the captured word
  assign raddr = hready ? req.haddr[ahb_mem_pkg::WORD_LSB +: ahb_mem_pkg::BANK_ABITS]
                        : addr_q[ahb_mem_pkg::WORD_LSB +: ahb_mem_pkg::BANK_ABITS];

  ram_1r1w #(
    .ABITS   (ahb_mem_pkg::BANK_ABITS)
  ) u_ram (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .waddr   (addr_q[ahb_mem_pkg::WORD_LSB +: ahb_mem_pkg::BANK_ABITS]),
    .we      (we_q & hready),
    .be      (be_q),
    .din     (req.hwdata),
    .raddr   (raddr),
    .dout    (dout)
  );

  // Response, errors come from the decoder
  assign rsp.hrdata    = dout;
  assign rsp.hreadyout = hreadyout_q;
  assign rsp.hresp     = ahb_mem_pkg::HRESP_OKAY;

endmodule

// File: rtl/ahb_mem_decoder.sv
// Address decoder and response multiplexer for the two SRAM banks.
// Holds a default slave that answers unmapped transfers with the
// two-cycle AHB ERROR response, and feeds the merged HREADY back.

module ahb_mem_decoder (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahb_mem_pkg::ahb_req_t req,
  input  ahb_mem_pkg::ahb_rsp_t rsp0,
  input  ahb_mem_pkg::ahb_rsp_t rsp1,
  output logic                  hsel0,
  output logic                  hsel1,
  output logic                  hready,
  output ahb_mem_pkg::ahb_rsp_t rsp
);

  // Address decode
  logic hit0;
  logic hit1;
  logic unmapped;
  logic active;
  logic err_start;

  // Data-phase owner, bit 0 bank 0, bit 1 bank 1, zero default slave
  logic [1:0] sel_q;

  // Default slave state
  logic [1:0] ds_state;
  logic [1:0] ds_next;

  // Selected response
  ahb_mem_pkg::ahb_rsp_t rsp_mux;

  //////////////////////////////////////////////////////////////////////
  // Address phase decode
  //////////////////////////////////////////////////////////////////////

  // Compare the bits above the bank offset
  assign hit0 = req.haddr[ahb_mem_pkg::ADDR_W-1:ahb_mem_pkg::BANK_LSB] ==
                ahb_mem_pkg::BANK0_BASE[ahb_mem_pkg::ADDR_W-1:ahb_mem_pkg::BANK_LSB];
  assign hit1 = req.haddr[ahb_mem_pkg::ADDR_W-1:ahb_mem_pkg::BANK_LSB] ==
                ahb_mem_pkg::BANK1_BASE[ahb_mem_pkg::ADDR_W-1:ahb_mem_pkg::BANK_LSB];
  assign unmapped = ~hit0 & ~hit1;

  assign hsel0 = hit0;
  assign hsel1 = hit1;

  // IDLE and BUSY never error
  assign active = (req.htrans != ahb_mem_pkg::HTRANS_IDLE) &&
                  (req.htrans != ahb_mem_pkg::HTRANS_BUSY);
  assign err_start = hready & active & unmapped;

  // Owner of the next data phase, taken at acceptance only
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sel_q <= 2'b00;
    end else if (hready) begin
      sel_q <= {hit1, hit0};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Default slave
  //////////////////////////////////////////////////////////////////////

  // ERR1 holds the bus, ERR2 releases it, both report ERROR
  always_comb begin
    ds_next = ds_state;
    case (ds_state)
      ahb_mem_pkg::DS_ERR1: ds_next = ahb_mem_pkg::DS_ERR2;
      // Idle or second error cycle may start another error
      default: ds_next = err_start ? ahb_mem_pkg::DS_ERR1 : ahb_mem_pkg::DS_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ds_state <= ahb_mem_pkg::DS_IDLE;
    end else begin
      ds_state <= ds_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response multiplexer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (sel_q)
      2'b01: rsp_mux = rsp0;
      2'b10: rsp_mux = rsp1;
      default: begin
        // Default slave returns no data
        rsp_mux.hrdata    = '0;
        rsp_mux.hreadyout = (ds_state != ahb_mem_pkg::DS_ERR1);
        rsp_mux.hresp     = (ds_state == ahb_mem_pkg::DS_IDLE) ?
                            ahb_mem_pkg::HRESP_OKAY : ahb_mem_pkg::HRESP_ERROR;
      end
    endcase
  end

  // Merged HREADY goes back to every slave
  assign rsp    = rsp_mux;
  assign hready = rsp_mux.hreadyout;

endmodule

// File: rtl/ahb_mem_top.sv
// Top level of the AHB-Lite memory subsystem.
// One master port, decoder with default slave, two 1 KiB SRAM banks.
// The decoder's merged HREADY is the bus HREADY for all slaves.

module ahb_mem_top (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahb_mem_pkg::ahb_req_t req,
  output ahb_mem_pkg::ahb_rsp_t rsp
);

  // Per-bank select from the decoder
  logic hsel0;
  logic hsel1;
  // Bus ready, fed back to the banks
  logic hready;

  // Bank responses into the multiplexer
  ahb_mem_pkg::ahb_rsp_t rsp0;
  ahb_mem_pkg::ahb_rsp_t rsp1;

  //////////////////////////////////////////////////////////////////////
  // Decoder and default slave
  //////////////////////////////////////////////////////////////////////

  ahb_mem_decoder u_decoder (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .req     (req),
    .rsp0    (rsp0),
    .rsp1    (rsp1),
    .hsel0   (hsel0),
    .hsel1   (hsel1),
    .hready  (hready),
    .rsp     (rsp)
  );

  //////////////////////////////////////////////////////////////////////
  // SRAM banks
  //////////////////////////////////////////////////////////////////////

  // Each bank uses only its low offset bits of haddr
  ahb_sram u_bank0 (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hsel    (hsel0),
    .hready  (hready),
    .req     (req),
    .rsp     (rsp0)
  );

  ahb_sram u_bank1 (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hsel    (hsel1),
    .hready  (hready),
    .req     (req),
    .rsp     (rsp1)
  );

endmodule

// File: tests/tb_vectors.svh
// Stimulus table for the memory subsystem testbench.
// Included inside the testbench module; build_vectors fills vec_q.

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Entry kinds
localparam logic [1:0] KIND_WR  = 2'd0;
localparam logic [1:0] KIND_RD  = 2'd1;
localparam logic [1:0] KIND_ERR = 2'd2;

typedef struct packed {
  logic [1:0]                     kind;
  logic [1:0]                     htrans;
  logic                           hwrite;
  logic [2:0]                     hsize;
  logic [ahb_mem_pkg::ADDR_W-1:0] haddr;
  logic [ahb_mem_pkg::DATA_W-1:0] hwdata;
} vec_t;

vec_t vec_q[$];

// Append one table entry
task automatic add_vec(input logic [1:0] kind, input logic [1:0] htrans, input logic hwrite,
                       input logic [2:0] hsize, input logic [15:0] haddr,
                       input logic [31:0] hwdata);
  vec_t v;
  v.kind   = kind;
  v.htrans = htrans;
  v.hwrite = hwrite;
  v.hsize  = hsize;
  v.haddr  = haddr;
  v.hwdata = hwdata;
  vec_q.push_back(v);
endtask

task automatic build_vectors();
  logic [15:0] words [8];
  // Full words at random offsets, even entries bank 0, odd bank 1
  for (int k = 0; k < 8; k++) begin
    words[k] = ((k % 2 == 0) ? ahb_mem_pkg::BANK0_BASE : ahb_mem_pkg::BANK1_BASE) |
               (16'($urandom) & 16'h03FC);
    add_vec(KIND_WR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, ahb_mem_pkg::HSIZE_WORD, words[k],
            $urandom);
  end
  for (int k = 0; k < 8; k++) begin
    add_vec(KIND_RD, (k % 2 == 0) ? ahb_mem_pkg::HTRANS_NONSEQ : ahb_mem_pkg::HTRANS_SEQ,
            1'b0, ahb_mem_pkg::HSIZE_WORD, words[k], '0);
  end
  // Full word then read of the same word, no wait
  for (int k = 0; k < 4; k++) begin
    add_vec(KIND_WR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, ahb_mem_pkg::HSIZE_WORD, words[k],
            $urandom);
    add_vec(KIND_RD, ahb_mem_pkg::HTRANS_NONSEQ, 1'b0, ahb_mem_pkg::HSIZE_WORD, words[k], '0);
  end
  // Bytes at every lane, IDLE gap before the read
  for (int k = 0; k < 4; k++) begin
    add_vec(KIND_WR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, ahb_mem_pkg::HSIZE_BYTE,
            words[0] + 16'(k), $urandom);
    add_vec(KIND_WR, ahb_mem_pkg::HTRANS_IDLE, 1'b0, ahb_mem_pkg::HSIZE_WORD, words[0], '0);
    add_vec(KIND_RD, ahb_mem_pkg::HTRANS_NONSEQ, 1'b0, ahb_mem_pkg::HSIZE_WORD, words[0], '0);
  end
  // Halfwords at both offsets
  for (int k = 0; k < 4; k += 2) begin
    add_vec(KIND_WR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, ahb_mem_pkg::HSIZE_HWORD,
            words[1] + 16'(k), $urandom);
    add_vec(KIND_WR, ahb_mem_pkg::HTRANS_IDLE, 1'b0, ahb_mem_pkg::HSIZE_WORD, words[1], '0);
    add_vec(KIND_RD, ahb_mem_pkg::HTRANS_NONSEQ, 1'b0, ahb_mem_pkg::HSIZE_WORD, words[1], '0);
  end
  // Partial write then read of the same word, one wait each
  add_vec(KIND_WR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, ahb_mem_pkg::HSIZE_BYTE,
          words[2] + 16'd1, $urandom);
  add_vec(KIND_RD, ahb_mem_pkg::HTRANS_NONSEQ, 1'b0, ahb_mem_pkg::HSIZE_WORD, words[2], '0);
  add_vec(KIND_WR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, ahb_mem_pkg::HSIZE_HWORD,
          words[3] + 16'd2, $urandom);
  add_vec(KIND_RD, ahb_mem_pkg::HTRANS_SEQ, 1'b0, ahb_mem_pkg::HSIZE_WORD, words[3], '0);
  // Unmapped accesses, some aliasing bank offsets
  add_vec(KIND_ERR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b0, ahb_mem_pkg::HSIZE_WORD,
          16'h0800 + (16'($urandom) & 16'hF7FC), '0);
  add_vec(KIND_ERR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, ahb_mem_pkg::HSIZE_WORD,
          16'h0800 | (words[0] & 16'h03FF), $urandom);
  add_vec(KIND_ERR, ahb_mem_pkg::HTRANS_SEQ, 1'b1, ahb_mem_pkg::HSIZE_BYTE,
          16'h0C00 | (words[1] & 16'h03FF), $urandom);
  add_vec(KIND_ERR, ahb_mem_pkg::HTRANS_NONSEQ, 1'b1, ahb_mem_pkg::HSIZE_WORD, 16'hFFFC,
          $urandom);
  // IDLE and BUSY with write intent must not write
  add_vec(KIND_WR, ahb_mem_pkg::HTRANS_IDLE, 1'b1, ahb_mem_pkg::HSIZE_WORD, words[4], $urandom);
  add_vec(KIND_WR, ahb_mem_pkg::HTRANS_BUSY, 1'b1, ahb_mem_pkg::HSIZE_WORD, words[5], $urandom);
  add_vec(KIND_WR, ahb_mem_pkg::HTRANS_IDLE, 1'b1, ahb_mem_pkg::HSIZE_BYTE, words[4] + 16'd3,
          $urandom);
  add_vec(KIND_WR, ahb_mem_pkg::HTRANS_BUSY, 1'b1, ahb_mem_pkg::HSIZE_WORD, 16'h0900, $urandom);
  // Final sweep confirms all contents
  for (int k = 0; k < 8; k++) begin
    add_vec(KIND_RD, ahb_mem_pkg::HTRANS_NONSEQ, 1'b0, ahb_mem_pkg::HSIZE_WORD, words[k], '0);
  end
endtask

`endif

// File: tests/tb_ahb_mem.sv
// Testbench for the AHB-Lite memory subsystem.
// Applies the vector table as a pipelined AHB-Lite master and checks
// responses, wait cycles and read data against a byte reference model.

module tb_ahb_mem;
  timeunit 1ns;
  timeprecision 1ps;

  // Longest stall tolerated before a phase counts as hung
  localparam int MAX_WAITS = 8;

  logic                  HCLK = 1'b0;
  logic                  HRESETn;
  ahb_mem_pkg::ahb_req_t req;
  ahb_mem_pkg::ahb_rsp_t rsp;

  logic [7:0] ref_mem [2048];
  bit         tests_ready = 1'b0;
  int         err_data = 0;
  int         err_resp = 0;
  int         err_wait = 0;

  `include "tb_vectors.svh"

  ahb_mem_top u_dut (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .req     (req),
    .rsp     (rsp)
  );

  always #50 HCLK = ~HCLK;

  //////////////////////////////////////////////////////////////////////
  // Bus rules and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic moves_data(input logic [1:0] htrans);
    return (htrans == ahb_mem_pkg::HTRANS_NONSEQ) || (htrans == ahb_mem_pkg::HTRANS_SEQ);
  endfunction

  // Everything below 16'h0800 is one of the two banks
  function automatic logic in_banks(input logic [15:0] haddr);
    return haddr < 16'h0800;
  endfunction

  // Little-endian word from the byte model
  function automatic logic [31:0] model_word(input logic [15:0] haddr);
    int a;
    a = int'(haddr) & 32'h7FC;
    return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
  endfunction

  // Bytes of a write land on the lanes named by their address
  task automatic model_write(input vec_t v);
    int base;
    int n;
    case (v.hsize)
      ahb_mem_pkg::HSIZE_BYTE: begin
        n    = 1;
        base = int'(v.haddr);
      end
      ahb_mem_pkg::HSIZE_HWORD: begin
        n    = 2;
        base = int'(v.haddr) & ~1;
      end
      default: begin
        n    = 4;
        base = int'(v.haddr) & ~3;
      end
    endcase
    for (int b = 0; b < n; b++) begin
      ref_mem[base+b] = v.hwdata[8*((base+b)%4) +: 8];
    end
  endtask

  // Unmapped active phases wait one cycle, and so does a read right after
  // a partial write of the same word
  function automatic int expected_waits(input int j);
    vec_t c;
    vec_t p;
    c = vec_q[j];
    if (moves_data(c.htrans) && !in_banks(c.haddr)) return 1;
    if (j == 0) return 0;
    p = vec_q[j-1];
    if (moves_data(p.htrans) && in_banks(p.haddr) && p.hwrite &&
        p.hsize != ahb_mem_pkg::HSIZE_WORD && moves_data(c.htrans) && in_banks(c.haddr) &&
        !c.hwrite && p.haddr[15:2] == c.haddr[15:2]) return 1;
    return 0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_rdata(input logic [ahb_mem_pkg::DATA_W-1:0] exp,
                             input logic [ahb_mem_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0d ns hrdata exp %h act %h", $time, exp, act);
      err_data++;
    end
  endtask

  // Only hresp and hreadyout are compared
  task automatic check_resp(input ahb_mem_pkg::ahb_rsp_t exp,
                            input ahb_mem_pkg::ahb_rsp_t act);
    if (act.hresp !== exp.hresp || act.hreadyout !== exp.hreadyout) begin
      $display("[ERROR] %0d ns hresp/hreadyout exp %b/%b act %b/%b", $time,
               exp.hresp, exp.hreadyout, act.hresp, act.hreadyout);
      err_resp++;
    end
  endtask

  // Wait cycles counted in one data phase
  task automatic check_waits(input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %0d ns wait_cycles exp %0d act %0d", $time, exp, act);
      err_wait++;
    end
  endtask

  // Follow one data phase to completion with mid-cycle samples
  task automatic finish_data_phase(input vec_t v, input int exp_waits);
    ahb_mem_pkg::ahb_rsp_t hold;
    ahb_mem_pkg::ahb_rsp_t done;
    int waits;
    hold = '0;
    hold.hresp = (moves_data(v.htrans) && !in_banks(v.haddr)) ?
                 ahb_mem_pkg::HRESP_ERROR : ahb_mem_pkg::HRESP_OKAY;
    done = hold;
    done.hreadyout = 1'b1;
    waits = 0;
    @(negedge HCLK);
    while (rsp.hreadyout !== 1'b1 && waits < MAX_WAITS) begin
      check_resp(hold, rsp);
      waits++;
      @(negedge HCLK);
    end
    check_resp(done, rsp);
    check_waits(exp_waits, waits);
    if (v.kind == KIND_RD) check_rdata(model_word(v.haddr), rsp.hrdata);
    if (moves_data(v.htrans) && in_banks(v.haddr) && v.hwrite) model_write(v);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    ahb_mem_pkg::ahb_req_t nxt;
    void'($urandom(32'h9288));
    HRESETn <= 1'b0;
    req     <= '0;
    build_vectors();
    tests_ready = 1'b1;
    repeat (5) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(posedge HCLK);
    // Address phase of entry i overlaps the data phase of entry i-1
    for (int i = 0; i <= vec_q.size(); i++) begin
      nxt = '0;
      nxt.htrans = ahb_mem_pkg::HTRANS_IDLE;
      if (i < vec_q.size()) begin
        nxt.haddr  = vec_q[i].haddr;
        nxt.hwrite = vec_q[i].hwrite;
        nxt.hsize  = vec_q[i].hsize;
        nxt.htrans = vec_q[i].htrans;
      end
      if (i > 0) nxt.hwdata = vec_q[i-1].hwdata;
      req <= nxt;
      if (i > 0) finish_data_phase(vec_q[i-1], expected_waits(i - 1));
      @(posedge HCLK);
    end
    $display("Errors: %0d data, %0d response, %0d wait", err_data, err_resp, err_wait);
    if (err_data + err_resp + err_wait == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog allows four cycles per entry plus reset and margin
  initial begin
    wait (tests_ready);
    #(100 * (vec_q.size() * 4 + 5 + 20));
    $display("Timeout: the vector table did not complete in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: flist.f
+incdir+tests
rtl/ahb_mem_pkg.sv
rtl/ram_1r1w.sv
rtl/ahb_sram.sv
rtl/ahb_mem_decoder.sv
rtl/ahb_mem_top.sv
tests/tb_ahb_mem.sv

// File: Makefile
# Verilator build and run for the AHB-Lite memory subsystem

SIM   := verilator
FLAGS := --binary --timing -Wno-fatal
TOP   := tb_ahb_mem
FLIST := flist.f
OBJ   := obj_dir

.PHONY: sim clean

# Build, run, and pass only when the pass line is in the output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf $(OBJ)
